/* build.f */
+incdir+.
histPkg.sv
histRam.sv
logNext.sv
histWay.sv
histBank.sv
histTb.sv

/* Bender.yml */
package:
  name: hist_bank

sources:
  - include_dirs:
      - .
    files:
      - histPkg.sv
      - histRam.sv
      - logNext.sv
      - histWay.sv
      - histBank.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - histTb.sv

/* histTb.sv */
`timescale 1ns/1ps
`include "hist_config.svh"

module histTb;
    import histPkg::*;

    localparam int Ways       = `HIST_WAYS;
    localparam int Entries    = 1 << `HIST_IDX_BITS;
    localparam int DirRows    = 34;
    localparam int RandomRows = 200;
    localparam int ReadyLimit = 64;     // polls of 2 ns

    typedef struct packed {
        wayMaskT  erSel;
        pcT       erPC;
        logic     erLower;
        logic     erUpper;
        wayMaskT  bdSel;
        pcT       bdPC;
        logic     bdBack;
        logic     bdBranch;
        instTypeT bdType;
        pcT       ifPC;
        wayIdxT   ifSel;
        logic     check;                // compare the predicted pair
    } rowT;

    logic     clk;
    logic     rstn;
    wayMaskT  erSel;
    pcT       erPC;
    logic     erLower;
    logic     erUpper;
    wayMaskT  bdSel;
    pcT       bdPC;
    logic     bdBack;
    logic     bdBranch;
    instTypeT bdType;
    pcT       ifPC;
    wayIdxT   ifSel;
    logic     ifVldLower;
    logic     ifVldUpper;
    histLogT  ifLogLower;
    histLogT  ifLogUpper;

    logic        mVld [Ways][Entries];  // reference valid bits
    histLogT     mLog [Ways][Entries];  // reference logs
    int          mismatchCount = 0;
    int          otherCount    = 0;
    int          edgeCount     = 0;
    logic        timedOut      = 1'b0;
    logic [31:0] rngState      = 32'h5f67_6e9a;

    //////////////////////////////////////////////////
    // directed rows
    //////////////////////////////////////////////////

    // erSel erPC erLo erUp | bdSel bdPC back branch type | ifPC ifSel check
    rowT dirRows [DirRows] = '{
        // fresh log of each type in way 0
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h1, 32'h00, 1'b0, 1'b0, 2'b00, 32'h00, 2'd0, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h1, 32'h04, 1'b0, 1'b1, 2'b01, 32'h00, 2'd0, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h1, 32'h08, 1'b1, 1'b0, 2'b01, 32'h00, 2'd0, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h1, 32'h0c, 1'b1, 1'b0, 2'b10, 32'h08, 2'd0, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h1, 32'h10, 1'b0, 1'b1, 2'b11, 32'h08, 2'd0, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h0, 32'h00, 1'b0, 1'b0, 2'b00, 32'hbeef_0012, 2'd0, 1'b1},
        // counter walk on entry 0x04 taken then not taken
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h1, 32'h04, 1'b0, 1'b1, 2'b01, 32'h00, 2'd0, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h1, 32'h04, 1'b0, 1'b1, 2'b01, 32'h00, 2'd0, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h1, 32'h04, 1'b0, 1'b1, 2'b01, 32'h00, 2'd0, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h1, 32'h04, 1'b0, 1'b1, 2'b01, 32'h00, 2'd0, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h1, 32'h04, 1'b0, 1'b0, 2'b01, 32'h00, 2'd0, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h1, 32'h04, 1'b0, 1'b0, 2'b01, 32'h00, 2'd0, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h1, 32'h04, 1'b0, 1'b0, 2'b01, 32'h00, 2'd0, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h1, 32'h04, 1'b0, 1'b0, 2'b01, 32'h00, 2'd0, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h1, 32'h04, 1'b0, 1'b0, 2'b01, 32'h00, 2'd0, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h0, 32'h00, 1'b0, 1'b0, 2'b00, 32'h00, 2'd0, 1'b1},
        // erase lower, upper and both, then erase against a build
        '{4'h1, 32'h00, 1'b1, 1'b0, 4'h0, 32'h00, 1'b0, 1'b0, 2'b00, 32'h00, 2'd0, 1'b1},
        '{4'h1, 32'h0c, 1'b0, 1'b1, 4'h0, 32'h00, 1'b0, 1'b0, 2'b00, 32'h00, 2'd0, 1'b1},
        '{4'h1, 32'h10, 1'b1, 1'b1, 4'h0, 32'h00, 1'b0, 1'b0, 2'b00, 32'h08, 2'd0, 1'b1},
        '{4'h1, 32'h08, 1'b1, 1'b1, 4'h1, 32'h08, 1'b0, 1'b1, 2'b01, 32'h10, 2'd0, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h0, 32'h00, 1'b0, 1'b0, 2'b00, 32'h08, 2'd0, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h1, 32'h08, 1'b0, 1'b0, 2'b01, 32'h08, 2'd0, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h0, 32'h00, 1'b0, 1'b0, 2'b00, 32'h08, 2'd0, 1'b1},
        // several ways at once with each way read back on its own
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'ha, 32'h20, 1'b1, 1'b1, 2'b01, 32'h20, 2'd1, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h6, 32'h20, 1'b0, 1'b0, 2'b01, 32'h20, 2'd1, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h0, 32'h00, 1'b0, 1'b0, 2'b00, 32'h20, 2'd0, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h0, 32'h00, 1'b0, 1'b0, 2'b00, 32'h20, 2'd1, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h0, 32'h00, 1'b0, 1'b0, 2'b00, 32'h20, 2'd2, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h0, 32'h00, 1'b0, 1'b0, 2'b00, 32'h20, 2'd3, 1'b1},
        '{4'h9, 32'h20, 1'b1, 1'b0, 4'h0, 32'h00, 1'b0, 1'b0, 2'b00, 32'h20, 2'd3, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h0, 32'h00, 1'b0, 1'b0, 2'b00, 32'h20, 2'd3, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h0, 32'h00, 1'b0, 1'b0, 2'b00, 32'h20, 2'd1, 1'b1},
        '{4'hf, 32'h20, 1'b1, 1'b1, 4'h0, 32'h00, 1'b0, 1'b0, 2'b00, 32'h20, 2'd2, 1'b1},
        '{4'h0, 32'h00, 1'b0, 1'b0, 4'h0, 32'h00, 1'b0, 1'b0, 2'b00, 32'h20, 2'd2, 1'b1}
    };

    histBank i_dut (
        .clk        (clk),
        .rstn       (rstn),
        .erSel      (erSel),
        .erPC       (erPC),
        .erLower    (erLower),
        .erUpper    (erUpper),
        .bdSel      (bdSel),
        .bdPC       (bdPC),
        .bdBack     (bdBack),
        .bdBranch   (bdBranch),
        .bdType     (bdType),
        .ifPC       (ifPC),
        .ifSel      (ifSel),
        .ifVldLower (ifVldLower),
        .ifVldUpper (ifVldUpper),
        .ifLogLower (ifLogLower),
        .ifLogUpper (ifLogUpper)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;          // rising edges at 4 + 8k ns
    end

    always @(posedge clk) edgeCount = edgeCount + 1;

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic histLogT freshLog(input instTypeT t, input logic back, input logic br);
        case (t)
            2'b00:   return '0;
            2'b01:   return back ? {1'b1, br, 8'ha9} : {1'b0, br, 8'h95};
            default: return '1;
        endcase
    endfunction

    function automatic histLogT updateLog(input histLogT old, input logic br);
        histLogT res;
        int      h;
        int      c;
        res = old;
        h   = old[9:8];
        c   = old[2*h +: 2];
        if (br && c < 3) begin
            c++;
        end else if (!br && c > 0) begin
            c--;
        end
        res[2*h +: 2] = c[1:0];
        res[9:8]      = {old[8], br};
        return res;
    endfunction

    // state change at the coming edge
    task automatic modelEdge(input rowT r);
        int b;
        int eLo;
        int eUp;
        b   = r.bdPC[7:2];
        eLo = {r.erPC[7:3], 1'b0};
        eUp = {r.erPC[7:3], 1'b1};
        for (int w = 0; w < Ways; w++) begin
            if (r.bdSel[w]) begin
                if (mVld[w][b]) begin
                    mLog[w][b] = updateLog(mLog[w][b], r.bdBranch);
                end else begin
                    mLog[w][b] = freshLog(r.bdType, r.bdBack, r.bdBranch);
                end
                mVld[w][b] = 1'b1;
            end
            if (r.erSel[w] && r.erLower) begin
                mVld[w][eLo] = 1'b0;
            end
            if (r.erSel[w] && r.erUpper) begin
                mVld[w][eUp] = 1'b0;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x        = rngState;
        x        = x ^ (x << 13);
        x        = x ^ (x >> 17);
        x        = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    // clears bits 7:5 so only pairs 0 to 3 are hit
    function automatic pcT confinePc(input logic [31:0] w);
        return w & 32'hffff_ff1f;
    endfunction

    task automatic reportTimeout(input string why);
        otherCount++;
        timedOut = 1'b1;
        $display("ERROR t=%0t %s", $time, why);
    endtask

    task automatic reportMismatch(input string name, input logic [9:0] got, input logic [9:0] exp);
        mismatchCount++;
        $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
    endtask

    // called at odd ns so polls stay clear of the edges
    task automatic waitEdges(input int n);
        int target;
        int steps;
        target = edgeCount + n;
        steps  = 0;
        while (edgeCount < target && steps < 8 * n) begin
            #2;
            steps++;
        end
        if (edgeCount < target) begin
            reportTimeout("clock stopped, no rising edge within the expected time");
        end
    endtask

    task automatic waitResetClear();
        int steps;
        steps = 0;
        while (!(ifVldLower === 1'b0 && ifVldUpper === 1'b0) && steps < ReadyLimit) begin
            #2;
            steps++;
        end
        if (!(ifVldLower === 1'b0 && ifVldUpper === 1'b0)) begin
            reportTimeout("predict valid outputs did not clear after reset");
        end
    endtask

    task automatic checkOutputs(input pcT pc, input wayIdxT way);
        int lo;
        int up;
        lo = {pc[7:3], 1'b0};
        up = {pc[7:3], 1'b1};
        assert (ifVldLower === mVld[way][lo])
            else reportMismatch("ifVldLower", ifVldLower, mVld[way][lo]);
        assert (ifVldUpper === mVld[way][up])
            else reportMismatch("ifVldUpper", ifVldUpper, mVld[way][up]);
        if (mVld[way][lo]) begin    // log undefined while invalid
            assert (ifLogLower === mLog[way][lo])
                else reportMismatch("ifLogLower", ifLogLower, mLog[way][lo]);
        end
        if (mVld[way][up]) begin
            assert (ifLogUpper === mLog[way][up])
                else reportMismatch("ifLogUpper", ifLogUpper, mLog[way][up]);
        end
    endtask

    // entered 1 ns after an edge and returns 1 ns after the next
    task automatic applyRow(input rowT r);
        erSel    = r.erSel;
        erPC     = r.erPC;
        erLower  = r.erLower;
        erUpper  = r.erUpper;
        bdSel    = r.bdSel;
        bdPC     = r.bdPC;
        bdBack   = r.bdBack;
        bdBranch = r.bdBranch;
        bdType   = r.bdType;
        ifPC     = r.ifPC;
        ifSel    = r.ifSel;
        #4;
        if (r.check) begin
            checkOutputs(r.ifPC, r.ifSel);
        end
        modelEdge(r);
        waitEdges(1);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        rowT         r;
        logic [31:0] ctrl;
        rstn     = 1'b0;
        erSel    = '0;
        erPC     = '0;
        erLower  = 1'b0;
        erUpper  = 1'b0;
        bdSel    = '0;
        bdPC     = '0;
        bdBack   = 1'b0;
        bdBranch = 1'b0;
        bdType   = '0;
        ifPC     = '0;
        ifSel    = '0;
        for (int w = 0; w < Ways; w++) begin
            for (int e = 0; e < Entries; e++) begin
                mVld[w][e] = 1'b0;
            end
        end
        #1;
        waitEdges(16);
        rstn = 1'b1;
        if (!timedOut) begin
            waitResetClear();
        end
        if (!timedOut) begin
            waitEdges(1);
        end

        // every pair of every way reads invalid
        for (int w = 0; w < Ways && !timedOut; w++) begin
            for (int p = 0; p < Entries / 2 && !timedOut; p++) begin
                r       = '0;
                r.ifPC  = pcT'(p * 8);
                r.ifSel = wayIdxT'(w);
                r.check = 1'b1;
                applyRow(r);
            end
        end

        for (int i = 0; i < DirRows && !timedOut; i++) begin
            applyRow(dirRows[i]);
        end

        for (int i = 0; i < RandomRows && !timedOut; i++) begin
            ctrl       = nextRandom();
            r.erSel    = (ctrl[1:0] == 2'b00) ? ctrl[5:2] : 4'h0;  // erase in about a quarter
            r.erPC     = confinePc(nextRandom());
            r.erLower  = ctrl[6];
            r.erUpper  = ctrl[7];
            r.bdSel    = ctrl[11:8];
            r.bdPC     = confinePc(nextRandom());
            r.bdBack   = ctrl[12];
            r.bdBranch = ctrl[13];
            r.bdType   = ctrl[15:14];
            r.ifPC     = confinePc(nextRandom());
            r.ifSel    = ctrl[17:16];
            r.check    = 1'b1;
            applyRow(r);
        end

        $display("errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
        if (mismatchCount == 0 && otherCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* histBank.sv */
`timescale 1ns/1ps
`include "hist_config.svh"

module histBank (
    input  logic              clk,
    input  logic              rstn,

    // erase, per-way mask
    input  histPkg::wayMaskT  erSel,
    input  histPkg::pcT       erPC,
    input  logic              erLower,
    input  logic              erUpper,

    // build, per-way mask
    input  histPkg::wayMaskT  bdSel,
    input  histPkg::pcT       bdPC,
    input  logic              bdBack,
    input  logic              bdBranch,
    input  histPkg::instTypeT bdType,

    // predict from a single way
    input  histPkg::pcT       ifPC,
    input  histPkg::wayIdxT   ifSel,
    output logic              ifVldLower,
    output logic              ifVldUpper,
    output histPkg::histLogT  ifLogLower,
    output histPkg::histLogT  ifLogUpper
);
    import histPkg::*;

    logic [`HIST_WAYS-1:0] wayVldLower;
    logic [`HIST_WAYS-1:0] wayVldUpper;
    histLogT               wayLogLower [`HIST_WAYS];
    histLogT               wayLogUpper [`HIST_WAYS];

    //////////////////////////////////////////////////
    // ways
    //////////////////////////////////////////////////

    // shared buses fan out, enables come from the masks
    for (genvar w = 0; w < `HIST_WAYS; w++) begin : way
        histWay histWayInst (
            .clk        (clk),
            .rstn       (rstn),

            .erEn       (erSel[w]),
            .erLower    (erLower),
            .erUpper    (erUpper),
            .erPC       (erPC),

            .bdEn       (bdSel[w]),
            .bdPC       (bdPC),
            .bdBack     (bdBack),
            .bdBranch   (bdBranch),
            .bdType     (bdType),

            .ifPC       (ifPC),
            .ifVldLower (wayVldLower[w]),
            .ifVldUpper (wayVldUpper[w]),
            .ifLogLower (wayLogLower[w]),
            .ifLogUpper (wayLogUpper[w])
        );
    end

    //////////////////////////////////////////////////
    // predict mux
    //////////////////////////////////////////////////

    // purely combinational, same cycle as ifPC and ifSel
    always_comb begin
        ifVldLower = wayVldLower[ifSel];
        ifVldUpper = wayVldUpper[ifSel];
        ifLogLower = wayLogLower[ifSel];
        ifLogUpper = wayLogUpper[ifSel];
    end

endmodule

/* histWay.sv */
`timescale 1ns/1ps
`include "hist_config.svh"

module histWay (
    input  logic              clk,
    input  logic              rstn,

    input  logic              erEn,         // erase this way
    input  logic              erLower,      // erase the even entry of the pair
    input  logic              erUpper,      // erase the odd entry of the pair
    input  histPkg::pcT       erPC,

    input  logic              bdEn,         // build into this way
    input  histPkg::pcT       bdPC,
    input  logic              bdBack,
    input  logic              bdBranch,
    input  histPkg::instTypeT bdType,

    input  histPkg::pcT       ifPC,
    output logic              ifVldLower,
    output logic              ifVldUpper,
    output histPkg::histLogT  ifLogLower,
    output histPkg::histLogT  ifLogUpper
);
    import histPkg::*;

    localparam int Entries = 1 << `HIST_IDX_BITS;

    logic [Entries-1:0] vld;
    logic [Entries-1:0] vldNext;

    entryIdxT bdIdx;
    entryIdxT erIdxLower;
    entryIdxT erIdxUpper;
    entryIdxT ifIdxLower;
    entryIdxT ifIdxUpper;

    logic     eraseLower;
    logic     eraseUpper;
    histLogT  bdOldLog;
    histLogT  bdNewLog;

    //////////////////////////////////////////////////
    // index decode
    //////////////////////////////////////////////////

    assign bdIdx      = bdPC[`HIST_IDX_BITS+1:2];           // single instruction
    assign erIdxLower = {erPC[`HIST_IDX_BITS+1:3], 1'b0};   // pair, even half
    assign erIdxUpper = {erPC[`HIST_IDX_BITS+1:3], 1'b1};
    assign ifIdxLower = {ifPC[`HIST_IDX_BITS+1:3], 1'b0};
    assign ifIdxUpper = {ifPC[`HIST_IDX_BITS+1:3], 1'b1};

    assign eraseLower = erEn & erLower;
    assign eraseUpper = erEn & erUpper;

    //////////////////////////////////////////////////
    // valid bits
    //////////////////////////////////////////////////

    // erase applied last so it wins on a shared entry
    always_comb begin
        vldNext = vld;
        if (bdEn) begin
            vldNext[bdIdx] = 1'b1;
        end
        if (eraseLower) begin
            vldNext[erIdxLower] = 1'b0;
        end
        if (eraseUpper) begin
            vldNext[erIdxUpper] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            vld <= '0;
        end else begin
            vld <= vldNext;
        end
    end

    //////////////////////////////////////////////////
    // storage and next log
    //////////////////////////////////////////////////

    histRam ram (
        .clk        (clk),
        .we         (bdEn),             // written even if erased this cycle
        .wAddr      (bdIdx),
        .wData      (bdNewLog),
        .rAddrBuild (bdIdx),
        .rAddrLower (ifIdxLower),
        .rAddrUpper (ifIdxUpper),
        .rDataBuild (bdOldLog),
        .rDataLower (ifLogLower),
        .rDataUpper (ifLogUpper)
    );

    logNext next (
        .valid      (vld[bdIdx]),       // state before the edge
        .oldLog     (bdOldLog),
        .branch     (bdBranch),
        .back       (bdBack),
        .instType   (bdType),
        .newLog     (bdNewLog)
    );

    assign ifVldLower = vld[ifIdxLower];
    assign ifVldUpper = vld[ifIdxUpper];

endmodule

/* logNext.sv */
`timescale 1ns/1ps

module logNext (
    input  logic              valid,      // entry already holds a log
    input  histPkg::histLogT  oldLog,     // stored log of the entry
    input  logic              branch,     // outcome of this execution
    input  logic              back,       // backward target
    input  histPkg::instTypeT instType,
    output histPkg::histLogT  newLog
);
    import histPkg::*;

    histLogT    freshLog;
    histLogT    updLog;
    logic [1:0] hist;       // indexes the counter to train
    logic [1:0] ctr;
    logic [1:0] ctrNext;

    //////////////////////////////////////////////////
    // fresh log for a first build
    //////////////////////////////////////////////////

    always_comb begin
        if (instType[1]) begin
            freshLog = '1;                          // unconditional, always taken
        end else if (instType[0]) begin
            if (back) begin
                freshLog = {back, branch, 8'b10_10_10_01};  // loops lean taken
            end else begin
                freshLog = {back, branch, 8'b10_01_01_01};
            end
        end else begin
            freshLog = '0;                          // not a branch
        end
    end

    //////////////////////////////////////////////////
    // update of a stored log
    //////////////////////////////////////////////////

    assign hist = oldLog[9:8];
    assign ctr  = oldLog[{hist, 1'b0} +: 2];

    // saturating 2-bit counter
    always_comb begin
        if (branch) begin
            ctrNext = (ctr == 2'b11) ? ctr : ctr + 2'd1;
        end else begin
            ctrNext = (ctr == 2'b00) ? ctr : ctr - 2'd1;
        end
    end

    always_comb begin
        updLog                     = oldLog;
        updLog[{hist, 1'b0} +: 2]  = ctrNext;
        updLog[9:8]                = {oldLog[8], branch};  // shift in outcome
    end

    //////////////////////////////////////////////////
    // select
    //////////////////////////////////////////////////

    assign newLog = valid ? updLog : freshLog;

endmodule

/* histRam.sv */
`timescale 1ns/1ps
`include "hist_config.svh"

module histRam (
    input  logic              clk,
    input  logic              we,           // write strobe, one entry
    input  histPkg::entryIdxT wAddr,
    input  histPkg::histLogT  wData,

    input  histPkg::entryIdxT rAddrBuild,   // read for the build update
    input  histPkg::entryIdxT rAddrLower,   // predicted pair, even entry
    input  histPkg::entryIdxT rAddrUpper,   // predicted pair, odd entry
    output histPkg::histLogT  rDataBuild,
    output histPkg::histLogT  rDataLower,
    output histPkg::histLogT  rDataUpper
);
    import histPkg::*;

    localparam int Depth = 1 << `HIST_IDX_BITS;

    histLogT mem [Depth];   // log array of one way

    //////////////////////////////////////////////////
    // write port
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wAddr] <= wData;
        end
    end

    //////////////////////////////////////////////////
    // asynchronous read ports
    //////////////////////////////////////////////////

    // old contents until the edge, new ones right after
    assign rDataBuild = mem[rAddrBuild];
    assign rDataLower = mem[rAddrLower];
    assign rDataUpper = mem[rAddrUpper];

endmodule

/* histPkg.sv */
`include "hist_config.svh"

package histPkg;

    //////////////////////////////////////////////////
    // address and index types
    //////////////////////////////////////////////////

    typedef logic [`HIST_PC_WIDTH-1:0]  pcT;        // instruction address
    typedef logic [`HIST_IDX_BITS-1:0]  entryIdxT;  // entry within one way

    //////////////////////////////////////////////////
    // payload types
    //////////////////////////////////////////////////

    // log layout, high to low
    //   [9:8] last two outcomes, older one in bit 9
    //   [7:0] counter k at bits 2k+1:2k, k is the history value
    typedef logic [`HIST_LOG_WIDTH-1:0] histLogT;

    // 00 not a branch, 01 conditional, 1x unconditional
    typedef logic [1:0]                 instTypeT;

    //////////////////////////////////////////////////
    // way selection types
    //////////////////////////////////////////////////

    typedef logic [`HIST_WAYS-1:0]         wayMaskT;  // one bit per way
    typedef logic [$clog2(`HIST_WAYS)-1:0] wayIdxT;   // way number

endpackage

/* hist_config.svh */
`ifndef HIST_CONFIG_SVH
`define HIST_CONFIG_SVH

//////////////////////////////////////////////////
// sizes of the pattern-history bank
//////////////////////////////////////////////////

// processor address width
`define HIST_PC_WIDTH  32

// entry address bits, 64 entries per way
`define HIST_IDX_BITS  6

// independent ways in the bank
`define HIST_WAYS      4

// 2 history bits plus four 2-bit counters
`define HIST_LOG_WIDTH 10

`endif
